//--- rtl/core_cfg_pkg.sv
package core_cfg_pkg;

   ////////////////////
   // Settings bus and readback types
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [3:0]  rb_addr_t;
   typedef logic [7:0]  led_t;

   ////////////////////
   // Settings address map
   localparam set_addr_t SR_MISC   = 8'd0;
   localparam set_addr_t SR_TIME64 = 8'd10;

   // Offsets inside the misc block
   localparam set_addr_t MISC_CLK     = 8'd0;
   localparam set_addr_t MISC_SERDES  = 8'd1;
   localparam set_addr_t MISC_ADC     = 8'd2;
   localparam set_addr_t MISC_LED_SW  = 8'd3;
   localparam set_addr_t MISC_PHY     = 8'd4;
   localparam set_addr_t MISC_LED_SRC = 8'd6;   // 5 is left free

   localparam led_t LED_SRC_AT_RESET = 8'h1E;   // Status LEDs on hardware

   ////////////////////
   // Readback words
   localparam set_data_t COMPAT_NUM = {16'd10, 16'd0};   // Major, minor
   localparam set_data_t RB_UNUSED  = 32'hFFFF_FFFF;

   localparam rb_addr_t RB_TIME_HI = 4'd0;
   localparam rb_addr_t RB_TIME_LO = 4'd1;
   localparam rb_addr_t RB_PPS_HI  = 4'd2;
   localparam rb_addr_t RB_PPS_LO  = 4'd3;
   localparam rb_addr_t RB_COMPAT  = 4'd4;
   localparam rb_addr_t RB_STATUS  = 4'd5;
   localparam rb_addr_t RB_LEDS    = 4'd6;

endpackage

//--- rtl/time_pkg.sv
package time_pkg;

   // VITA time, seconds and ticks kept as one count
   typedef logic [63:0] vita_time_t;

   typedef logic time_mode_t;

   ////////////////////
   // Register offsets from the time base address
   localparam logic [7:0] TIME_HI_OFS   = 8'd0;   // Pending upper word
   localparam logic [7:0] TIME_LO_OFS   = 8'd1;   // Commits the load
   localparam logic [7:0] TIME_MODE_OFS = 8'd2;

   ////////////////////
   // Load modes
   localparam time_mode_t TIME_MODE_NOW = 1'b0;
   localparam time_mode_t TIME_MODE_PPS = 1'b1;   // Wait for next PPS edge

endpackage

//--- rtl/setting_reg.sv
module setting_reg #(
   parameter core_cfg_pkg::set_addr_t MY_ADDR = '0,
   parameter type payload_t = logic [7:0],
   parameter payload_t AT_RESET = '0
) (
   input  logic                    dsp_clk,
   input  logic                    por_rst,
   input  logic                    set_stb_i,
   input  core_cfg_pkg::set_addr_t set_addr_i,
   input  core_cfg_pkg::set_data_t set_data_i,
   output payload_t                out_o,
   output logic                    changed_o
);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == MY_ADDR);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         out_o     <= AT_RESET;
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;   // One cycle per write
         if (hit) begin
            // Keep only the low bits that fit the payload
            out_o <= payload_t'(set_data_i[$bits(payload_t)-1:0]);
         end
      end
   end

   // A change pulse always traces back to a write at this address
   a_changed_after_hit: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      changed_o |-> $past(hit)
   );

endmodule

//--- rtl/host_input_sync.sv
module host_input_sync (
   input  logic                    dsp_clk,
   input  logic                    por_rst,
   input  logic                    set_stb_i,
   input  core_cfg_pkg::set_addr_t set_addr_i,
   input  core_cfg_pkg::set_data_t set_data_i,
   input  logic                    pps_i,
   output logic                    set_stb_o,
   output core_cfg_pkg::set_addr_t set_addr_o,
   output core_cfg_pkg::set_data_t set_data_o,
   output logic                    pps_pulse_o
);

   logic pps_meta;   // First stage, may go metastable
   logic pps_sync;
   logic pps_last;

   ////////////////////
   // Settings bus register stage
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_stb_o <= 1'b0;
      end else begin
         set_stb_o <= set_stb_i;
      end
   end

   always_ff @(posedge dsp_clk) begin
      set_addr_o <= set_addr_i;
      set_data_o <= set_data_i;
   end

   ////////////////////
   // PPS synchronizer and rising edge detect
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_last <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_last <= pps_sync;
      end
   end

   assign pps_pulse_o = pps_sync & ~pps_last;

   a_pps_single: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      pps_pulse_o |=> !pps_pulse_o
   );

endmodule

//--- rtl/vita_timer.sv
module vita_timer #(
   parameter core_cfg_pkg::set_addr_t BASE_TIME = core_cfg_pkg::SR_TIME64
) (
   input  logic                    dsp_clk,
   input  logic                    por_rst,
   input  logic                    set_stb_i,
   input  core_cfg_pkg::set_addr_t set_addr_i,
   input  core_cfg_pkg::set_data_t set_data_i,
   input  logic                    pps_pulse_i,
   output time_pkg::vita_time_t    vita_time_o,
   output time_pkg::vita_time_t    vita_time_pps_o,
   output logic                    pps_int_o,
   output logic                    good_sync_o
);

   import core_cfg_pkg::*;
   import time_pkg::*;

   localparam set_addr_t ADDR_HI   = BASE_TIME + TIME_HI_OFS;
   localparam set_addr_t ADDR_LO   = BASE_TIME + TIME_LO_OFS;
   localparam set_addr_t ADDR_MODE = BASE_TIME + TIME_MODE_OFS;

   set_data_t  time_hi_q;      // Upper word waiting for a LO write
   time_mode_t mode_q;
   vita_time_t armed_time_q;
   logic       armed_q;
   logic       wr_hi;
   logic       wr_lo;
   logic       wr_mode;
   logic       load_now;
   logic       arm_wr;

   assign wr_hi    = set_stb_i && (set_addr_i == ADDR_HI);
   assign wr_lo    = set_stb_i && (set_addr_i == ADDR_LO);
   assign wr_mode  = set_stb_i && (set_addr_i == ADDR_MODE);
   assign load_now = wr_lo && (mode_q == TIME_MODE_NOW);
   assign arm_wr   = wr_lo && (mode_q == TIME_MODE_PPS);

   ////////////////////
   // Time registers
   always_ff @(posedge dsp_clk) begin
      if (wr_hi) begin
         time_hi_q <= set_data_i;
      end
      if (arm_wr) begin
         armed_time_q <= {time_hi_q, set_data_i};
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         mode_q <= TIME_MODE_NOW;
      end else if (wr_mode) begin
         mode_q <= time_mode_t'(set_data_i[0]);
      end
   end

   ////////////////////
   // Counter with immediate and PPS-armed load
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o <= '0;
         armed_q     <= 1'b0;
      end else begin
         if (load_now) begin
            vita_time_o <= {time_hi_q, set_data_i};
         end else if (pps_pulse_i && armed_q) begin
            vita_time_o <= armed_time_q;
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end

         // A fresh arm wins over the PPS that consumes the old one
         if (arm_wr) begin
            armed_q <= 1'b1;
         end else if (pps_pulse_i) begin
            armed_q <= 1'b0;
         end
      end
   end

   // PPS timestamp, interrupt and sync flag
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_pps_o <= '0;
         pps_int_o       <= 1'b0;
         good_sync_o     <= 1'b0;
      end else begin
         pps_int_o <= pps_pulse_i;
         if (pps_pulse_i) begin
            vita_time_pps_o <= vita_time_o;
            good_sync_o     <= 1'b1;   // Sticky until reset
         end
      end
   end

   a_arm_clear: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      (armed_q && !arm_wr) |=> (armed_q == !$past(pps_pulse_i))
   );

endmodule

//--- rtl/misc_ctrl.sv
module misc_ctrl #(
   parameter core_cfg_pkg::set_addr_t BASE_MISC = core_cfg_pkg::SR_MISC
) (
   input  logic                    dsp_clk,
   input  logic                    por_rst,
   input  logic                    set_stb_i,
   input  core_cfg_pkg::set_addr_t set_addr_i,
   input  core_cfg_pkg::set_data_t set_data_i,
   input  logic                    run_rx_i,
   input  logic                    run_tx_i,
   input  logic                    clk_status_i,
   input  logic                    serdes_link_up_i,
   input  logic                    good_sync_i,
   output core_cfg_pkg::led_t      leds_o,
   output logic                    clock_ready_o,
   output logic [1:0]              clk_en_o,
   output logic [1:0]              clk_sel_o,
   output logic [3:0]              ser_ctrl_o,
   output logic [3:0]              adc_ctrl_o,
   output logic                    phy_reset_n_o
);

   import core_cfg_pkg::*;

   logic [7:0] clock_outs;
   logic [7:0] serdes_outs;
   logic [7:0] adc_outs;
   logic       phy_reset;
   led_t       led_sw;
   led_t       led_src;    // 1 picks hardware, 0 picks software
   led_t       led_hw;

   ////////////////////
   // Control registers
   setting_reg #(.MY_ADDR(BASE_MISC + MISC_CLK), .payload_t(logic [7:0]), .AT_RESET(8'h00))
      sr_clk (.dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
              .out_o(clock_outs), .changed_o());

   setting_reg #(.MY_ADDR(BASE_MISC + MISC_SERDES), .payload_t(logic [7:0]), .AT_RESET(8'h00))
      sr_ser (.dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
              .out_o(serdes_outs), .changed_o());

   setting_reg #(.MY_ADDR(BASE_MISC + MISC_ADC), .payload_t(logic [7:0]), .AT_RESET(8'h00))
      sr_adc (.dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
              .out_o(adc_outs), .changed_o());

   setting_reg #(.MY_ADDR(BASE_MISC + MISC_LED_SW), .payload_t(led_t), .AT_RESET(8'h00))
      sr_led (.dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
              .out_o(led_sw), .changed_o());

   setting_reg #(.MY_ADDR(BASE_MISC + MISC_LED_SRC), .payload_t(led_t),
                 .AT_RESET(LED_SRC_AT_RESET))
      sr_led_src (.dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
                  .out_o(led_src), .changed_o());

   // PHY reset, active high in the register
   setting_reg #(.MY_ADDR(BASE_MISC + MISC_PHY), .payload_t(logic), .AT_RESET(1'b0))
      sr_phy (.dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
              .out_o(phy_reset), .changed_o());

   ////////////////////
   // Pin mapping
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_outs[4:0];
   assign ser_ctrl_o    = serdes_outs[3:0];   // enable, prbsen, loopen, rx_en
   assign adc_ctrl_o    = adc_outs[3:0];      // oe_a, on_a, oe_b, on_b
   assign phy_reset_n_o = ~phy_reset;

   // LED sources
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

//--- rtl/readback_mux.sv
module readback_mux (
   input  logic                    dsp_clk,
   input  logic                    por_rst,
   input  logic                    rb_stb_i,
   input  core_cfg_pkg::rb_addr_t  rb_addr_i,
   input  time_pkg::vita_time_t    vita_time_i,
   input  time_pkg::vita_time_t    vita_time_pps_i,
   input  logic                    clk_status_i,
   input  logic                    serdes_link_up_i,
   input  logic                    good_sync_i,
   input  core_cfg_pkg::led_t      leds_i,
   output core_cfg_pkg::set_data_t rb_data_o,
   output logic                    rb_ack_o
);

   import core_cfg_pkg::*;

   set_data_t status_word;
   set_data_t word_sel;

   assign status_word = {29'd0, clk_status_i, serdes_link_up_i, good_sync_i};

   ////////////////////
   // Word select
   always_comb begin
      case (rb_addr_i)
         RB_TIME_HI: word_sel = vita_time_i[63:32];
         RB_TIME_LO: word_sel = vita_time_i[31:0];
         RB_PPS_HI:  word_sel = vita_time_pps_i[63:32];
         RB_PPS_LO:  word_sel = vita_time_pps_i[31:0];
         RB_COMPAT:  word_sel = COMPAT_NUM;
         RB_STATUS:  word_sel = status_word;
         RB_LEDS:    word_sel = {24'd0, leds_i};
         default:    word_sel = RB_UNUSED;
      endcase
   end

   // Ack one cycle after each strobe
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= word_sel;   // Snapshot at the strobe edge
      end
   end

   a_ack_follows_stb: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      rb_ack_o |-> $past(rb_stb_i)
   );

endmodule

//--- rtl/u2_ctrl_core.sv
module u2_ctrl_core #(
   parameter core_cfg_pkg::set_addr_t BASE_MISC = core_cfg_pkg::SR_MISC,
   parameter core_cfg_pkg::set_addr_t BASE_TIME = core_cfg_pkg::SR_TIME64
) (
   input  logic                    dsp_clk,
   input  logic                    por_rst,
   // Settings bus
   input  logic                    set_stb_i,
   input  core_cfg_pkg::set_addr_t set_addr_i,
   input  core_cfg_pkg::set_data_t set_data_i,
   // Status levels and PPS
   input  logic                    pps_i,
   input  logic                    run_rx_i,
   input  logic                    run_tx_i,
   input  logic                    clk_status_i,
   input  logic                    serdes_link_up_i,
   // Readback request
   input  logic                    rb_stb_i,
   input  core_cfg_pkg::rb_addr_t  rb_addr_i,
   // Board controls
   output core_cfg_pkg::led_t      leds_o,
   output logic                    clock_ready_o,
   output logic [1:0]              clk_en_o,
   output logic [1:0]              clk_sel_o,
   output logic [3:0]              ser_ctrl_o,
   output logic [3:0]              adc_ctrl_o,
   output logic                    phy_reset_n_o,
   output logic                    pps_int_o,
   output core_cfg_pkg::set_data_t rb_data_o,
   output logic                    rb_ack_o
);

   import core_cfg_pkg::*;
   import time_pkg::*;

   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   logic       pps_pulse;
   logic       good_sync;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   ////////////////////
   // Input side
   host_input_sync u_input (
      .dsp_clk, .por_rst,
      .set_stb_i, .set_addr_i, .set_data_i, .pps_i,
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .pps_pulse_o(pps_pulse)
   );

   ////////////////////
   // Time and control
   vita_timer #(.BASE_TIME(BASE_TIME)) u_timer (
      .dsp_clk, .por_rst,
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_pulse_i(pps_pulse),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .pps_int_o, .good_sync_o(good_sync)
   );

   misc_ctrl #(.BASE_MISC(BASE_MISC)) u_misc (
      .dsp_clk, .por_rst,
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .run_rx_i, .run_tx_i, .clk_status_i, .serdes_link_up_i,
      .good_sync_i(good_sync),
      .leds_o, .clock_ready_o, .clk_en_o, .clk_sel_o,
      .ser_ctrl_o, .adc_ctrl_o, .phy_reset_n_o
   );

   ////////////////////
   // Output side
   readback_mux u_readback (
      .dsp_clk, .por_rst,
      .rb_stb_i, .rb_addr_i,
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .clk_status_i, .serdes_link_up_i,
      .good_sync_i(good_sync),
      .leds_i(leds_o),   // LED state as driven on the pins
      .rb_data_o, .rb_ack_o
   );

endmodule

//--- tb/tb_u2_ctrl_core.sv
module tb_u2_ctrl_core;

   import core_cfg_pkg::*;
   import time_pkg::*;

   logic      dsp_clk;
   logic      por_rst;
   logic      set_stb_i;
   set_addr_t set_addr_i;
   set_data_t set_data_i;
   logic      pps_i;
   logic      run_rx_i;
   logic      run_tx_i;
   logic      clk_status_i;
   logic      serdes_link_up_i;
   logic      rb_stb_i;
   rb_addr_t  rb_addr_i;
   led_t      leds_o;
   logic      clock_ready_o;
   logic [1:0] clk_en_o;
   logic [1:0] clk_sel_o;
   logic [3:0] ser_ctrl_o;
   logic [3:0] adc_ctrl_o;
   logic      phy_reset_n_o;
   logic      pps_int_o;
   set_data_t rb_data_o;
   logic      rb_ack_o;
   set_data_t pins;

   longint unsigned cycles = 64'd0;
   longint unsigned limit  = 64'd0;
   int              errors = 0;

   u2_ctrl_core dut (.*);

   // Control pins packed as in the K lines of the vector file
   assign pins = {18'd0, phy_reset_n_o, adc_ctrl_o, ser_ctrl_o,
                  clock_ready_o, clk_en_o, clk_sel_o};

   always #5 dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) begin
      cycles <= cycles + 64'd1;
      if (limit != 64'd0 && cycles >= limit) begin
         $display("Timeout: the run went past %0d cycles", limit);
         $display("Done: errors found");
         $finish;
      end
   end

   ////////////////////
   // Bus helpers
   task automatic next_cycle();
      @(posedge dsp_clk);
      #1;   // Drive point after the edge
   endtask

   task automatic bus_write(input set_addr_t addr, input set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      next_cycle();
      set_stb_i = 1'b0;
   endtask

   task automatic read_word(input rb_addr_t idx, output set_data_t data);
      int waited;
      rb_stb_i  = 1'b1;
      rb_addr_i = idx;
      next_cycle();
      rb_stb_i = 1'b0;
      waited   = 1;
      while (!rb_ack_o && waited < 4) begin
         next_cycle();
         waited++;
      end
      if (!rb_ack_o || waited != 1) begin
         $display("Readback of word %0d was not acknowledged one cycle after its strobe", idx);
         errors++;
      end
      data = rb_data_o;
   endtask

   task automatic read_time(input rb_addr_t hi_idx, output vita_time_t value);
      set_data_t hi;
      set_data_t lo;
      read_word(hi_idx, hi);
      read_word(hi_idx + 4'd1, lo);
      value = {hi, lo};
   endtask

   ////////////////////
   // Compare tasks
   task automatic check_word(input set_data_t got, input set_data_t exp, input string what);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_leds(input led_t got, input led_t exp);
      if (got !== exp) begin
         $display("mismatch at %0t: leds got %h, expected %h", $time, got, exp);
         errors++;
      end
   endtask

   task automatic check_time(input vita_time_t got, input vita_time_t lo_bound,
                             input vita_time_t hi_bound, input string what);
      if (got < lo_bound || got > hi_bound) begin
         $display("mismatch at %0t: %s got %h, expected %h to %h",
                  $time, what, got, lo_bound, hi_bound);
         errors++;
      end
   endtask

   ////////////////////
   // Test operations
   task automatic pulse_pps();
      int edges;
      edges = 0;
      pps_i = 1'b1;
      while (!pps_int_o && edges < 8) begin
         next_cycle();
         edges++;
      end
      if (!pps_int_o || edges < 3 || edges > 4) begin
         $display("PPS interrupt came %0d edges after the PPS input rose, not 3 to 4", edges);
         errors++;
      end
      next_cycle();
      if (pps_int_o) begin
         $display("PPS interrupt stayed high for more than one cycle");
         errors++;
      end
      pps_i = 1'b0;
   endtask

   task automatic immediate_load(input set_data_t hi, input set_data_t lo, input int gap);
      vita_time_t loaded;
      vita_time_t got;
      loaded = {hi, lo};
      bus_write(SR_TIME64 + TIME_MODE_OFS, {31'd0, TIME_MODE_NOW});
      bus_write(SR_TIME64 + TIME_HI_OFS, hi);
      bus_write(SR_TIME64 + TIME_LO_OFS, lo);
      repeat (gap) next_cycle();
      // Low word sampled gap+1 edges after the load edge
      read_time(RB_TIME_HI, got);
      check_time(got, loaded + 64'(gap), loaded + 64'(gap), "time after immediate load");
   endtask

   task automatic armed_load(input set_data_t hi, input set_data_t lo);
      vita_time_t      armed;
      vita_time_t      t0;
      vita_time_t      t1;
      vita_time_t      tp;
      vita_time_t      t2;
      longint unsigned c0;
      longint unsigned c1;
      longint unsigned cp;
      armed = {hi, lo};
      c0    = cycles;
      read_time(RB_TIME_HI, t0);
      bus_write(SR_TIME64 + TIME_MODE_OFS, {31'd0, TIME_MODE_PPS});
      bus_write(SR_TIME64 + TIME_HI_OFS, hi);
      bus_write(SR_TIME64 + TIME_LO_OFS, lo);
      next_cycle();
      next_cycle();
      c1 = cycles;
      read_time(RB_TIME_HI, t1);
      check_time(t1, t0, t0 + (cycles - c0), "live time while armed");
      cp = cycles;
      pulse_pps();
      read_time(RB_PPS_HI, tp);
      check_time(tp, t1, t1 + (cycles - c1), "PPS time");
      read_time(RB_TIME_HI, t2);
      check_time(t2, armed, armed + (cycles - cp), "live time after PPS load");
   endtask

   task automatic burst_read(input set_data_t exp4, input set_data_t exp6,
                             input set_data_t exp5);
      rb_addr_t  idx [3];
      set_data_t exp [3];
      idx = '{RB_COMPAT, RB_LEDS, RB_STATUS};
      exp = '{exp4, exp6, exp5};
      rb_stb_i = 1'b1;
      for (int k = 0; k < 3; k++) begin
         rb_addr_i = idx[k];
         next_cycle();   // Ack for this strobe is due now
         if (!rb_ack_o) begin
            $display("No acknowledge one cycle after the strobe to word %0d", idx[k]);
            errors++;
         end
         check_word(rb_data_o, exp[k], $sformatf("burst word %0d", idx[k]));
      end
      rb_stb_i = 1'b0;
      next_cycle();
      if (rb_ack_o) begin
         $display("Acknowledge still high after the last strobe of the burst");
         errors++;
      end
   endtask

   task automatic run_vector(input string line);
      byte       op;
      string     args;
      set_data_t a;
      set_data_t b;
      set_data_t c;
      set_data_t got;
      op   = line[0];
      args = line.substr(1, line.len() - 1);
      a    = '0;
      b    = '0;
      c    = '0;
      void'($sscanf(args, "%h %h %h", a, b, c));
      case (op)
         "W": begin
            bus_write(set_addr_t'(a), b);
            repeat (2) next_cycle();   // Sync stage plus register stage
         end
         "R": begin
            read_word(rb_addr_t'(a), got);
            check_word(got, b, $sformatf("readback word %0d", a));
         end
         "K": check_word(pins, a, "control pins");
         "L": check_leds(leds_o, led_t'(a));
         "S": begin
            {run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i} = a[3:0];
            next_cycle();   // Let the LED mux settle
         end
         "N": repeat (a) next_cycle();
         "P": pulse_pps();
         "T": immediate_load(a, b, int'(c));
         "A": armed_load(a, b);
         "B": burst_read(a, b, c);
         default: begin
            $display("Unknown operation in vector line: %s", line);
            errors++;
         end
      endcase
   endtask

   ////////////////////
   // Main sequence
   initial begin
      string     lines[$];
      string     line;
      int        fd;
      int        failed_tests;
      int        errors_before;
      set_data_t a;
      set_data_t b;
      set_data_t c;
      dsp_clk          = 1'b0;
      por_rst          = 1'b1;
      set_stb_i        = 1'b0;
      set_addr_i       = '0;
      set_data_i       = '0;
      pps_i            = 1'b0;
      run_rx_i         = 1'b0;
      run_tx_i         = 1'b0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      rb_stb_i         = 1'b0;
      rb_addr_i        = '0;
      failed_tests     = 0;
      void'($urandom(21));

      fd = $fopen("tb/ctrl_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file tb/ctrl_vectors.txt");
         errors++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
               lines.push_back(line);
            end
         end
         $fclose(fd);
      end

      // Budget of 40 cycles per line plus all explicit waits
      foreach (lines[i]) begin
         line = lines[i];
         a    = '0;
         b    = '0;
         c    = '0;
         void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
         limit += 64'd40;
         if (line[0] == "N") limit += 64'(a);
         if (line[0] == "T") limit += 64'(c);
      end
      limit += 64'd10;   // Reset

      repeat (3) @(posedge dsp_clk);
      #1;
      por_rst = 1'b0;

      foreach (lines[i]) begin
         errors_before = errors;
         run_vector(lines[i]);
         line = lines[i];
         if (errors == errors_before) begin
            $display("test %0d (%c): pass", i + 1, line[0]);
         end else begin
            $display("test %0d (%c): FAIL", i + 1, line[0]);
            failed_tests++;
         end
         repeat ($urandom % 4) next_cycle();   // Idle gap
      end

      $display("Tests run: %0d, failed: %0d, errors: %0d", lines.size(), failed_tests, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- tb/ctrl_vectors.txt
# Columns: op, then hex fields. W addr data | R index word | K pins | L leds | S status
# N cycles | P | T hi lo cycles | A hi lo | B word4 word6 word5 (S = tx,rx,clk,link)
K 2000
L 00
R 4 000A0000
R 9 FFFFFFFF
W 00 0000001F
W 01 0000000A
W 02 00000005
W 04 00000001
K 0B5F
W 03 000000FF
L E1
S F
L FD
W 06 000000FF
L 1C
W 06 00000000
L FF
N 8
T 00000001 00001000 6
A 00000002 40000000
R 5 00000007
W 06 000000FF
L 1E
P
B 000A0000 0000001E 00000007
S 0
L 00

//--- src.f
rtl/core_cfg_pkg.sv
rtl/time_pkg.sv
rtl/setting_reg.sv
rtl/host_input_sync.sv
rtl/vita_timer.sv
rtl/misc_ctrl.sv
rtl/readback_mux.sv
rtl/u2_ctrl_core.sv
tb/tb_u2_ctrl_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the u2_ctrl_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_u2_ctrl_core -f src.f -o tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
   exit 1
fi
exit 0
